/* src/soc_bus_pkg.sv */
package soc_bus_pkg;

	typedef logic [31:0]  addr_t;
	typedef logic [31:0]  data_t;
	typedef logic [3:0]   strb_t;
	typedef logic [1:0]   resp_t;
	typedef logic [127:0] line_t;
	typedef logic [15:0]  mask_t;
	typedef logic [7:0]   line_addr_t;
	typedef logic [3:0]   led_t;

	// AXI response codes
	localparam resp_t RESP_OKAY   = 2'd0;
	localparam resp_t RESP_SLVERR = 2'd2;
	localparam resp_t RESP_DECERR = 2'd3;

	// address map
	localparam addr_t APB_ADDR_BASE = 32'h1fe0_0000;
	localparam addr_t APB_ADDR_END  = 32'h1fe0_ffff;
	localparam addr_t MEM_ADDR_BASE = 32'h0000_0000;
	localparam addr_t MEM_ADDR_END  = 32'h0000_0fff;   // 4 KB, 256 lines

	// offsets inside the APB window
	localparam addr_t LED_REG_OFS     = 32'h0000_0000;
	localparam addr_t SCRATCH_REG_OFS = 32'h0000_0004;

	typedef enum logic [1:0] {
		DEC_IDLE,
		DEC_BUSY,   // address phase, then waiting on the target
		DEC_RESP
	} dec_state_t;

	typedef enum logic [1:0] {
		APB_IDLE,
		APB_SETUP,
		APB_ACCESS
	} apb_state_t;

endpackage

/* src/axil_decoder.sv */
`timescale 1ns/10ps

module axil_decoder (
	input  logic                clk,
	input  logic                rst,

	input  soc_bus_pkg::addr_t  s_axi_awaddr,
	input  logic                s_axi_awvalid,
	output logic                s_axi_awready,
	input  soc_bus_pkg::data_t  s_axi_wdata,
	input  soc_bus_pkg::strb_t  s_axi_wstrb,
	input  logic                s_axi_wvalid,
	output logic                s_axi_wready,
	output soc_bus_pkg::resp_t  s_axi_bresp,
	output logic                s_axi_bvalid,
	input  logic                s_axi_bready,
	input  soc_bus_pkg::addr_t  s_axi_araddr,
	input  logic                s_axi_arvalid,
	output logic                s_axi_arready,
	output soc_bus_pkg::data_t  s_axi_rdata,
	output soc_bus_pkg::resp_t  s_axi_rresp,
	output logic                s_axi_rvalid,
	input  logic                s_axi_rready,

	output logic                apb_req,
	input  logic                apb_done,
	input  soc_bus_pkg::data_t  apb_rdata,
	input  logic                apb_err,
	output logic                mem_req,
	input  logic                mem_done,
	input  soc_bus_pkg::data_t  mem_rdata,

	output logic                req_we,
	output soc_bus_pkg::addr_t  req_addr,
	output soc_bus_pkg::data_t  req_wdata,
	output soc_bus_pkg::strb_t  req_wstrb
);
	import soc_bus_pkg::*;

	dec_state_t state;
	logic       apb_hit;
	logic       mem_hit;
	logic       handshake;
	logic       finish;
	resp_t      resp;
	data_t      rdata_next;

	assign apb_hit = (req_addr >= APB_ADDR_BASE) && (req_addr <= APB_ADDR_END);
	assign mem_hit = (req_addr >= MEM_ADDR_BASE) && (req_addr <= MEM_ADDR_END);

	assign handshake = s_axi_awready || s_axi_arready;   // first busy cycle
	// no select raised after the handshake means the address missed
	assign finish = apb_done || mem_done || (!apb_req && !mem_req);

	always_comb begin
		if (apb_done && apb_err)
			resp = RESP_SLVERR;
		else if (!apb_req && !mem_req)
			resp = RESP_DECERR;
		else
			resp = RESP_OKAY;
	end

	always_comb begin
		if (apb_done)
			rdata_next = apb_rdata;
		else if (mem_done)
			rdata_next = mem_rdata;
		else
			rdata_next = '0;   // decode miss
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state         <= DEC_IDLE;
			s_axi_awready <= 1'b0;
			s_axi_wready  <= 1'b0;
			s_axi_arready <= 1'b0;
			s_axi_bvalid  <= 1'b0;
			s_axi_rvalid  <= 1'b0;
			apb_req       <= 1'b0;
			mem_req       <= 1'b0;
		end else begin
			case (state)
			DEC_IDLE: begin
				if (s_axi_awvalid && s_axi_wvalid) begin   // writes win
					s_axi_awready <= 1'b1;
					s_axi_wready  <= 1'b1;
					state         <= DEC_BUSY;
				end else if (s_axi_arvalid) begin
					s_axi_arready <= 1'b1;
					state         <= DEC_BUSY;
				end
			end
			DEC_BUSY: begin
				if (handshake) begin
					s_axi_awready <= 1'b0;
					s_axi_wready  <= 1'b0;
					s_axi_arready <= 1'b0;
					apb_req       <= apb_hit;
					mem_req       <= mem_hit;
				end else if (finish) begin
					apb_req <= 1'b0;
					mem_req <= 1'b0;
					if (req_we)
						s_axi_bvalid <= 1'b1;
					else
						s_axi_rvalid <= 1'b1;
					state <= DEC_RESP;
				end
			end
			DEC_RESP: begin
				if ((s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready)) begin
					s_axi_bvalid <= 1'b0;
					s_axi_rvalid <= 1'b0;
					state        <= DEC_IDLE;
				end
			end
			default: state <= DEC_IDLE;
			endcase
		end
	end

	// request and response payload
	always_ff @(posedge clk) begin
		if (state == DEC_IDLE) begin
			if (s_axi_awvalid && s_axi_wvalid) begin
				req_we    <= 1'b1;
				req_addr  <= s_axi_awaddr;
				req_wdata <= s_axi_wdata;
				req_wstrb <= s_axi_wstrb;
			end else if (s_axi_arvalid) begin
				req_we   <= 1'b0;
				req_addr <= s_axi_araddr;
			end
		end
		if (state == DEC_BUSY && !handshake && finish) begin
			if (req_we) begin
				s_axi_bresp <= resp;
			end else begin
				s_axi_rresp <= resp;
				s_axi_rdata <= rdata_next;
			end
		end
	end

endmodule

/* src/axil_to_apb.sv */
`timescale 1ns/10ps

module axil_to_apb (
	input  logic                clk,
	input  logic                rst,

	input  logic                apb_req,
	input  logic                req_we,
	input  soc_bus_pkg::addr_t  req_addr,
	input  soc_bus_pkg::data_t  req_wdata,
	input  soc_bus_pkg::strb_t  req_wstrb,
	output logic                apb_done,
	output soc_bus_pkg::data_t  apb_rdata,
	output logic                apb_err,

	output logic                psel,
	output logic                penable,
	output logic                pwrite,
	output soc_bus_pkg::addr_t  paddr,
	output soc_bus_pkg::data_t  pwdata,
	output soc_bus_pkg::strb_t  pstrb,
	input  soc_bus_pkg::data_t  prdata,
	input  logic                pslverr,
	input  logic                pready
);
	import soc_bus_pkg::*;

	apb_state_t state;
	logic       start;
	logic       complete;

	// select is still high in the done cycle, so skip it
	assign start    = (state == APB_IDLE) && apb_req && !apb_done;
	assign complete = (state == APB_ACCESS) && pready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= APB_IDLE;
			psel     <= 1'b0;
			penable  <= 1'b0;
			apb_done <= 1'b0;
		end else begin
			apb_done <= 1'b0;
			case (state)
			APB_IDLE: begin
				if (start) begin
					psel  <= 1'b1;
					state <= APB_SETUP;
				end
			end
			APB_SETUP: begin
				penable <= 1'b1;
				state   <= APB_ACCESS;
			end
			APB_ACCESS: begin
				if (pready) begin   // wait states allowed
					psel     <= 1'b0;
					penable  <= 1'b0;
					apb_done <= 1'b1;
					state    <= APB_IDLE;
				end
			end
			default: state <= APB_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			pwrite <= req_we;
			paddr  <= req_addr & (APB_ADDR_END - APB_ADDR_BASE);   // window offset
			pwdata <= req_wdata;
			pstrb  <= req_wstrb;
		end
		if (complete) begin
			apb_rdata <= prdata;
			apb_err   <= pslverr;
		end
	end

endmodule

/* src/apb_led_regs.sv */
`timescale 1ns/10ps

module apb_led_regs (
	input  logic                clk,
	input  logic                rst,

	input  logic                psel,
	input  logic                penable,
	input  logic                pwrite,
	input  soc_bus_pkg::addr_t  paddr,
	input  soc_bus_pkg::data_t  pwdata,
	input  soc_bus_pkg::strb_t  pstrb,
	output soc_bus_pkg::data_t  prdata,
	output logic                pslverr,
	output logic                pready,

	output soc_bus_pkg::led_t   led
);
	import soc_bus_pkg::*;

	led_t  led_reg;
	data_t scratch;
	logic  sel_led;
	logic  sel_scratch;
	logic  wr_en;

	assign sel_led     = (paddr == LED_REG_OFS);
	assign sel_scratch = (paddr == SCRATCH_REG_OFS);
	assign wr_en       = psel && penable && pwrite;

	assign pready  = 1'b1;   // no wait states
	assign pslverr = psel && !sel_led && !sel_scratch;
	assign led     = led_reg;

	always_comb begin
		if (sel_led)
			prdata = {28'd0, led_reg};
		else if (sel_scratch)
			prdata = scratch;
		else
			prdata = '0;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			led_reg <= '0;
			scratch <= '0;
		end else if (wr_en) begin
			if (sel_led && pstrb[0])
				led_reg <= pwdata[3:0];
			if (sel_scratch) begin
				for (int i = 0; i < 4; i++)
					if (pstrb[i])
						scratch[i*8 +: 8] <= pwdata[i*8 +: 8];
			end
		end
	end

endmodule

/* src/axil_width_adapter.sv */
`timescale 1ns/10ps

module axil_width_adapter (
	input  logic                    clk,
	input  logic                    rst,

	input  logic                    mem_req,
	input  logic                    req_we,
	input  soc_bus_pkg::addr_t      req_addr,
	input  soc_bus_pkg::data_t      req_wdata,
	input  soc_bus_pkg::strb_t      req_wstrb,
	output logic                    mem_done,
	output soc_bus_pkg::data_t      mem_rdata,

	output logic                    ram_en,
	output logic                    ram_we,
	output soc_bus_pkg::line_addr_t ram_addr,
	output soc_bus_pkg::mask_t      ram_wmask,
	output soc_bus_pkg::line_t      ram_wdata,
	input  soc_bus_pkg::line_t      ram_rdata
);
	import soc_bus_pkg::*;

	logic [1:0] cnt;    // cycles until done
	logic [1:0] lane;   // word lane of the read in flight
	logic [1:0] req_lane;
	logic       start;

	assign req_lane  = req_addr[3:2];
	assign start     = mem_req && (cnt == 2'd0);
	assign mem_done  = (cnt == 2'd1);
	assign mem_rdata = ram_rdata[lane*32 +: 32];

	always_ff @(posedge clk) begin
		if (rst) begin
			cnt    <= 2'd0;
			ram_en <= 1'b0;
		end else begin
			ram_en <= start;
			if (start)
				cnt <= req_we ? 2'd1 : 2'd2;   // read waits on the RAM
			else if (cnt != 2'd0)
				cnt <= cnt - 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			ram_we    <= req_we;
			ram_addr  <= req_addr[11:4];
			ram_wmask <= mask_t'(req_wstrb) << {req_lane, 2'b00};
			ram_wdata <= {4{req_wdata}};   // same word in every lane
			lane      <= req_lane;
		end
	end

endmodule

/* src/wide_ram.sv */
`timescale 1ns/10ps

module wide_ram (
	input  logic                    clk,
	input  logic                    ram_en,
	input  logic                    ram_we,
	input  soc_bus_pkg::line_addr_t ram_addr,
	input  soc_bus_pkg::mask_t      ram_wmask,
	input  soc_bus_pkg::line_t      ram_wdata,
	output soc_bus_pkg::line_t      ram_rdata
);
	import soc_bus_pkg::*;

	line_t mem [0:255];

	always_ff @(posedge clk) begin
		if (ram_en) begin
			if (ram_we) begin
				for (int i = 0; i < 16; i++)
					if (ram_wmask[i])
						mem[ram_addr][i*8 +: 8] <= ram_wdata[i*8 +: 8];
			end else begin
				ram_rdata <= mem[ram_addr];   // one cycle read
			end
		end
	end

endmodule

/* src/soc_bus_top.sv */
`timescale 1ns/10ps

module soc_bus_top (
	input  logic                clk,
	input  logic                rst,

	input  soc_bus_pkg::addr_t  s_axi_awaddr,
	input  logic                s_axi_awvalid,
	output logic                s_axi_awready,
	input  soc_bus_pkg::data_t  s_axi_wdata,
	input  soc_bus_pkg::strb_t  s_axi_wstrb,
	input  logic                s_axi_wvalid,
	output logic                s_axi_wready,
	output soc_bus_pkg::resp_t  s_axi_bresp,
	output logic                s_axi_bvalid,
	input  logic                s_axi_bready,
	input  soc_bus_pkg::addr_t  s_axi_araddr,
	input  logic                s_axi_arvalid,
	output logic                s_axi_arready,
	output soc_bus_pkg::data_t  s_axi_rdata,
	output soc_bus_pkg::resp_t  s_axi_rresp,
	output logic                s_axi_rvalid,
	input  logic                s_axi_rready,

	output soc_bus_pkg::led_t   led
);
	import soc_bus_pkg::*;

	// internal request, shared by both targets
	logic       req_we;
	addr_t      req_addr;
	data_t      req_wdata;
	strb_t      req_wstrb;
	logic       apb_req;
	logic       apb_done;
	data_t      apb_rdata;
	logic       apb_err;
	logic       mem_req;
	logic       mem_done;
	data_t      mem_rdata;

	// APB
	logic       psel;
	logic       penable;
	logic       pwrite;
	addr_t      paddr;
	data_t      pwdata;
	strb_t      pstrb;
	data_t      prdata;
	logic       pslverr;
	logic       pready;

	// RAM port
	logic       ram_en;
	logic       ram_we;
	line_addr_t ram_addr;
	mask_t      ram_wmask;
	line_t      ram_wdata;
	line_t      ram_rdata;

	axil_decoder u_decoder (
		.clk           (clk),
		.rst           (rst),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.apb_req       (apb_req),
		.apb_done      (apb_done),
		.apb_rdata     (apb_rdata),
		.apb_err       (apb_err),
		.mem_req       (mem_req),
		.mem_done      (mem_done),
		.mem_rdata     (mem_rdata),
		.req_we        (req_we),
		.req_addr      (req_addr),
		.req_wdata     (req_wdata),
		.req_wstrb     (req_wstrb)
	);

	axil_to_apb u_apb_bridge (
		.clk       (clk),
		.rst       (rst),
		.apb_req   (apb_req),
		.req_we    (req_we),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.pstrb     (pstrb),
		.prdata    (prdata),
		.pslverr   (pslverr),
		.pready    (pready),
		.apb_done  (apb_done),
		.apb_rdata (apb_rdata),
		.apb_err   (apb_err)
	);

	apb_led_regs u_led_regs (
		.clk     (clk),
		.rst     (rst),
		.psel    (psel),
		.penable (penable),
		.pwrite  (pwrite),
		.paddr   (paddr),
		.pwdata  (pwdata),
		.pstrb   (pstrb),
		.prdata  (prdata),
		.pslverr (pslverr),
		.pready  (pready),
		.led     (led)
	);

	axil_width_adapter u_width_adapter (
		.clk       (clk),
		.rst       (rst),
		.mem_req   (mem_req),
		.req_we    (req_we),
		.req_addr  (req_addr),
		.req_wdata (req_wdata),
		.req_wstrb (req_wstrb),
		.mem_done  (mem_done),
		.mem_rdata (mem_rdata),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wmask (ram_wmask),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

	wide_ram u_ram (
		.clk       (clk),
		.ram_en    (ram_en),
		.ram_we    (ram_we),
		.ram_addr  (ram_addr),
		.ram_wmask (ram_wmask),
		.ram_wdata (ram_wdata),
		.ram_rdata (ram_rdata)
	);

endmodule

/* tb/clk_gen.sv */
`timescale 1ns/10ps

module clk_gen (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;   // 10 ns period
	end

	initial begin
		rst = 1'b1;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
	end

endmodule

/* tb/soc_bus_properties.sv */
`timescale 1ns/10ps

module soc_bus_properties (
	input logic               clk,
	input logic               rst,
	input logic               s_axi_awvalid,
	input logic               s_axi_wvalid,
	input logic               s_axi_awready,
	input logic               s_axi_wready,
	input logic               s_axi_arready,
	input logic               s_axi_bvalid,
	input logic               s_axi_bready,
	input soc_bus_pkg::resp_t s_axi_bresp,
	input logic               s_axi_rvalid,
	input logic               s_axi_rready,
	input soc_bus_pkg::resp_t s_axi_rresp,
	input soc_bus_pkg::data_t s_axi_rdata,
	input logic               apb_req,
	input logic               mem_req,
	input logic               psel,
	input logic               penable
);

	b_held: assert property (@(posedge clk) disable iff (rst)
		s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid && $stable(s_axi_bresp))
		else $error("bvalid or bresp changed before bready");

	r_held: assert property (@(posedge clk) disable iff (rst)
		s_axi_rvalid && !s_axi_rready |=>
			s_axi_rvalid && $stable(s_axi_rresp) && $stable(s_axi_rdata))
		else $error("rvalid, rresp or rdata changed before rready");

	// write taken only with both valids, one cycle
	ready_pair: assert property (@(posedge clk) disable iff (rst)
		s_axi_awready || s_axi_wready |->
			s_axi_awready && s_axi_wready && $past(s_axi_awvalid && s_axi_wvalid)
			##1 !s_axi_awready)
		else $error("awready and wready not a one-cycle pair after both valids");

	// setup phase is exactly one cycle
	setup_then_access: assert property (@(posedge clk) disable iff (rst)
		psel && !penable |=> psel && penable)
		else $error("penable did not follow psel");

	access_after_setup: assert property (@(posedge clk) disable iff (rst)
		$rose(penable) |-> psel && $past(psel))
		else $error("penable rose without a setup cycle");

	idle_in_reset: assert property (@(posedge clk)
		rst |=> !(s_axi_awready || s_axi_wready || s_axi_arready || s_axi_bvalid
			|| s_axi_rvalid || apb_req || mem_req || psel || penable))
		else $error("control output active during reset");

endmodule

bind axil_decoder soc_bus_properties u_dec_props (
	.clk           (clk),
	.rst           (rst),
	.s_axi_awvalid (s_axi_awvalid),
	.s_axi_wvalid  (s_axi_wvalid),
	.s_axi_awready (s_axi_awready),
	.s_axi_wready  (s_axi_wready),
	.s_axi_arready (s_axi_arready),
	.s_axi_bvalid  (s_axi_bvalid),
	.s_axi_bready  (s_axi_bready),
	.s_axi_bresp   (s_axi_bresp),
	.s_axi_rvalid  (s_axi_rvalid),
	.s_axi_rready  (s_axi_rready),
	.s_axi_rresp   (s_axi_rresp),
	.s_axi_rdata   (s_axi_rdata),
	.apb_req       (apb_req),
	.mem_req       (mem_req),
	.psel          (1'b0),
	.penable       (1'b0)
);

bind axil_to_apb soc_bus_properties u_apb_props (
	.clk           (clk),
	.rst           (rst),
	.s_axi_awvalid (1'b0),
	.s_axi_wvalid  (1'b0),
	.s_axi_awready (1'b0),
	.s_axi_wready  (1'b0),
	.s_axi_arready (1'b0),
	.s_axi_bvalid  (1'b0),
	.s_axi_bready  (1'b0),
	.s_axi_bresp   (2'b00),
	.s_axi_rvalid  (1'b0),
	.s_axi_rready  (1'b0),
	.s_axi_rresp   (2'b00),
	.s_axi_rdata   (32'd0),
	.apb_req       (apb_req),
	.mem_req       (1'b0),
	.psel          (psel),
	.penable       (penable)
);

/* tb/tb_soc_bus.sv */
`timescale 1ns/10ps

module tb_soc_bus;
	import soc_bus_pkg::*;

	localparam int timeout_cycles = 50;

	typedef enum {sig_awready, sig_arready, sig_bvalid, sig_rvalid} wait_sig_t;

	logic  clk;
	logic  rst;
	addr_t s_axi_awaddr;
	logic  s_axi_awvalid;
	logic  s_axi_awready;
	data_t s_axi_wdata;
	strb_t s_axi_wstrb;
	logic  s_axi_wvalid;
	logic  s_axi_wready;
	resp_t s_axi_bresp;
	logic  s_axi_bvalid;
	logic  s_axi_bready;
	addr_t s_axi_araddr;
	logic  s_axi_arvalid;
	logic  s_axi_arready;
	data_t s_axi_rdata;
	resp_t s_axi_rresp;
	logic  s_axi_rvalid;
	logic  s_axi_rready;
	led_t  led;

	// reference model state
	led_t        led_model = '0;
	data_t       scratch_model = '0;
	logic [7:0]  mem_model [0:4095];
	addr_t       mem_words [$];

	// expected responses, oldest first
	string       exp_tag_q [$];
	bit          exp_read_q [$];
	resp_t       exp_resp_q [$];
	data_t       exp_data_q [$];

	integer      seed;
	int          checks = 0;
	int          errors = 0;
	int          tests = 0;
	int          checks_mark = 0;
	int          errors_mark = 0;
	bit          hung = 1'b0;

	clk_gen u_clk_gen (
		.clk (clk),
		.rst (rst)
	);

	soc_bus_top uut (
		.clk           (clk),
		.rst           (rst),
		.s_axi_awaddr  (s_axi_awaddr),
		.s_axi_awvalid (s_axi_awvalid),
		.s_axi_awready (s_axi_awready),
		.s_axi_wdata   (s_axi_wdata),
		.s_axi_wstrb   (s_axi_wstrb),
		.s_axi_wvalid  (s_axi_wvalid),
		.s_axi_wready  (s_axi_wready),
		.s_axi_bresp   (s_axi_bresp),
		.s_axi_bvalid  (s_axi_bvalid),
		.s_axi_bready  (s_axi_bready),
		.s_axi_araddr  (s_axi_araddr),
		.s_axi_arvalid (s_axi_arvalid),
		.s_axi_arready (s_axi_arready),
		.s_axi_rdata   (s_axi_rdata),
		.s_axi_rresp   (s_axi_rresp),
		.s_axi_rvalid  (s_axi_rvalid),
		.s_axi_rready  (s_axi_rready),
		.led           (led)
	);

	function automatic resp_t model_access(input logic we, input addr_t addr,
			input data_t wdata, input strb_t strb, output data_t rdata);
		addr_t       ofs;
		logic [11:0] base;
		rdata = '0;
		if (addr >= APB_ADDR_BASE && addr <= APB_ADDR_END) begin
			ofs = addr - APB_ADDR_BASE;
			if (ofs == LED_REG_OFS) begin
				if (we && strb[0])
					led_model = wdata[3:0];
				rdata = {28'd0, led_model};
			end else if (ofs == SCRATCH_REG_OFS) begin
				for (int i = 0; i < 4; i++)
					if (we && strb[i])
						scratch_model[i*8 +: 8] = wdata[i*8 +: 8];
				rdata = scratch_model;
			end else begin
				return RESP_SLVERR;   // undefined offset, nothing changes
			end
			return RESP_OKAY;
		end
		if (addr >= MEM_ADDR_BASE && addr <= MEM_ADDR_END) begin
			base = {addr[11:2], 2'b00};
			for (int i = 0; i < 4; i++) begin
				if (we && strb[i])
					mem_model[base + i] = wdata[i*8 +: 8];
				rdata[i*8 +: 8] = mem_model[base + i];
			end
			return RESP_OKAY;
		end
		return RESP_DECERR;
	endfunction

	task automatic compare(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
		end
	endtask

	task automatic wait_for(input wait_sig_t sig, input string tag);
		int   n;
		logic seen;
		n = 0;
		seen = 1'b0;
		while (!seen && n < timeout_cycles) begin
			@(posedge clk);
			n++;
			case (sig)
			sig_awready: seen = (s_axi_awready === 1'b1);
			sig_arready: seen = (s_axi_arready === 1'b1);
			sig_bvalid:  seen = (s_axi_bvalid === 1'b1);
			default:     seen = (s_axi_rvalid === 1'b1);
			endcase
		end
		if (!seen) begin
			$display("timeout: %s never rose during %s", sig.name(), tag);
			errors++;
			hung = 1'b1;
		end
	endtask

	task automatic write_word(input string tag, input addr_t addr, input data_t data,
			input strb_t strb, input int delay);
		data_t unused;
		if (hung)
			return;
		exp_tag_q.push_back($sformatf("%s wr %h", tag, addr));
		exp_read_q.push_back(1'b0);
		exp_resp_q.push_back(model_access(1'b1, addr, data, strb, unused));
		exp_data_q.push_back('0);
		s_axi_awaddr  <= addr;
		s_axi_awvalid <= 1'b1;
		s_axi_wdata   <= data;
		s_axi_wstrb   <= strb;
		s_axi_wvalid  <= 1'b1;
		wait_for(sig_awready, tag);
		s_axi_awvalid <= 1'b0;
		s_axi_wvalid  <= 1'b0;
		if (hung)
			return;
		wait_for(sig_bvalid, tag);
		if (hung)
			return;
		repeat (delay) @(posedge clk);   // back-pressure
		s_axi_bready <= 1'b1;
		@(posedge clk);
		s_axi_bready <= 1'b0;
	endtask

	task automatic read_word(input string tag, input addr_t addr, input int delay);
		data_t exp_data;
		resp_t exp_resp;
		if (hung)
			return;
		exp_resp = model_access(1'b0, addr, '0, '0, exp_data);
		exp_tag_q.push_back($sformatf("%s rd %h", tag, addr));
		exp_read_q.push_back(1'b1);
		exp_resp_q.push_back(exp_resp);
		exp_data_q.push_back(exp_data);
		s_axi_araddr  <= addr;
		s_axi_arvalid <= 1'b1;
		wait_for(sig_arready, tag);
		s_axi_arvalid <= 1'b0;
		if (hung)
			return;
		wait_for(sig_rvalid, tag);
		if (hung)
			return;
		repeat (delay) @(posedge clk);
		s_axi_rready <= 1'b1;
		@(posedge clk);
		s_axi_rready <= 1'b0;
	endtask

	task automatic finish_test(input string name);
		int n;
		n = 0;
		while (exp_tag_q.size() != 0 && !hung && n < timeout_cycles) begin
			@(posedge clk);
			n++;
		end
		if (exp_tag_q.size() != 0 && !hung) begin
			$display("responses still missing at the end of %s", name);
			errors++;
			hung = 1'b1;
		end
		@(negedge clk);
		tests++;
		$display("%-16s %0d checks, %0d errors", name, checks - checks_mark,
			errors - errors_mark);
		checks_mark = checks;
		errors_mark = errors;
		@(posedge clk);
	endtask

	// every B and R handshake is matched against the oldest expectation
	always @(posedge clk) begin : compare_responses
		string tag;
		bit    is_read;
		resp_t exp_resp;
		data_t exp_data;
		if (!rst && ((s_axi_bvalid && s_axi_bready) || (s_axi_rvalid && s_axi_rready))) begin
			if (exp_tag_q.size() == 0) begin
				$display("response seen with no transaction outstanding");
				errors++;
			end else begin
				tag = exp_tag_q.pop_front();
				is_read = exp_read_q.pop_front();
				exp_resp = exp_resp_q.pop_front();
				exp_data = exp_data_q.pop_front();
				if (is_read != s_axi_rvalid) begin
					$display("response for %s came on the wrong channel", tag);
					errors++;
				end else if (is_read) begin
					compare({tag, " resp"}, exp_resp, s_axi_rresp);
					compare({tag, " data"}, exp_data, s_axi_rdata);
				end else begin
					compare({tag, " resp"}, exp_resp, s_axi_bresp);
				end
			end
		end
	end

	initial begin
		addr_t      line_base;
		addr_t      addr;
		int         n;
		int         sel;
		addr_t      unmapped [4];
		addr_t      bad_ofs [2];
		unmapped = '{32'h0000_1000, 32'h2000_0000, 32'h1fdf_fffc, 32'h1fe1_0000};
		bad_ofs = '{32'h1fe0_0008, 32'h1fe0_fffc};
		seed = 32'hc6b8_9fe3;
		s_axi_awaddr  = '0;
		s_axi_awvalid = 1'b0;
		s_axi_wdata   = '0;
		s_axi_wstrb   = '0;
		s_axi_wvalid  = 1'b0;
		s_axi_bready  = 1'b0;
		s_axi_araddr  = '0;
		s_axi_arvalid = 1'b0;
		s_axi_rready  = 1'b0;

		n = 0;
		do begin
			@(posedge clk);
			n++;
		end while (rst !== 1'b0 && n < timeout_cycles);
		if (rst !== 1'b0) begin
			$display("reset was never released");
			errors++;
			hung = 1'b1;
		end

		compare("led after reset", {28'd0, led_model}, {28'd0, led});
		read_word("reset", APB_ADDR_BASE + LED_REG_OFS, 0);
		read_word("reset", APB_ADDR_BASE + SCRATCH_REG_OFS, 0);
		finish_test("reset values");

		for (int i = 0; i < 6; i++) begin
			write_word("led", APB_ADDR_BASE + LED_REG_OFS, $random(seed),
				strb_t'($random(seed)), 0);
			compare("led output", {28'd0, led_model}, {28'd0, led});
			read_word("led", APB_ADDR_BASE + LED_REG_OFS, 0);
		end
		finish_test("led register");

		for (int i = 0; i < 8; i++) begin
			write_word("scratch", APB_ADDR_BASE + SCRATCH_REG_OFS, $random(seed),
				strb_t'($random(seed)), 0);
			read_word("scratch", APB_ADDR_BASE + SCRATCH_REG_OFS, 0);
		end
		finish_test("scratch register");

		for (int l = 0; l < 4; l++) begin
			line_base = {20'd0, 8'($random(seed)), 4'd0};
			for (int k = 0; k < 4; k++) begin   // fill the whole line first
				write_word("mem init", line_base + k * 4, $random(seed), 4'hf, 0);
				mem_words.push_back(line_base + k * 4);
			end
			for (int r = 0; r < 3; r++) begin
				write_word("mem", line_base + ($unsigned($random(seed)) % 4) * 4,
					$random(seed), strb_t'($random(seed)), 0);
				for (int k = 0; k < 4; k++)
					read_word("mem", line_base + k * 4, 0);
			end
		end
		finish_test("memory");

		foreach (unmapped[i]) begin
			write_word("unmapped", unmapped[i], $random(seed), 4'hf, 0);
			read_word("unmapped", unmapped[i], 0);
		end
		foreach (bad_ofs[i]) begin
			write_word("bad offset", bad_ofs[i], $random(seed), 4'hf, 0);
			read_word("bad offset", bad_ofs[i], 0);
		end
		read_word("after errors", APB_ADDR_BASE + LED_REG_OFS, 0);
		read_word("after errors", APB_ADDR_BASE + SCRATCH_REG_OFS, 0);
		finish_test("errors");

		for (int i = 0; i < 16; i++) begin
			sel = $unsigned($random(seed)) % 4;
			if (sel == 0)
				addr = APB_ADDR_BASE + LED_REG_OFS;
			else if (sel == 1)
				addr = APB_ADDR_BASE + SCRATCH_REG_OFS;
			else
				addr = mem_words[$unsigned($random(seed)) % mem_words.size()];
			if ($random(seed) & 1)
				write_word("stall", addr, $random(seed), strb_t'($random(seed)),
					$unsigned($random(seed)) % 8);
			else
				read_word("stall", addr, $unsigned($random(seed)) % 8);
		end
		finish_test("back-pressure");

		@(negedge clk);
		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* soc_bus_top.f */
src/soc_bus_pkg.sv
src/axil_decoder.sv
src/axil_to_apb.sv
src/apb_led_regs.sv
src/axil_width_adapter.sv
src/wide_ram.sv
src/soc_bus_top.sv
tb/clk_gen.sv
tb/soc_bus_properties.sv
tb/tb_soc_bus.sv
